//--- Bender.yml
package:
  name: mk14_loader

sources:
  - src/mk14_pkg.sv
  - src/uart_rx.sv
  - src/intel_hex.sv
  - src/mem_map.sv
  - src/boot_sequencer.sv
  - src/mk14_loader_soc.sv
  - target: simulation
    files:
      - verif/tb_mk14_loader_asserts.sv
      - verif/tb_mk14_loader.sv

//--- flist.f
src/mk14_pkg.sv
src/uart_rx.sv
src/intel_hex.sv
src/mem_map.sv
src/boot_sequencer.sv
src/mk14_loader_soc.sv
verif/tb_mk14_loader_asserts.sv
verif/tb_mk14_loader.sv

//--- src/boot_sequencer.sv
// boot state machine with load window timeout, core enable and halt key

module boot_sequencer #(
	parameter int RX_TIMEOUT_CYCLES = 100_000_000
)
(
	input logic clk,
	input logic soft_reset,
	input logic i_load_done,
	input logic i_halt_key,
	output logic o_rx_wait,
	output logic o_core_en
);

	localparam int CNT_W = $clog2(RX_TIMEOUT_CYCLES + 1);

	mk14_pkg::boot_state_e state;
	logic [CNT_W-1:0] timeout_cnt;

	assign o_rx_wait = (state == mk14_pkg::ST_RX_WAIT);

	always_ff @(posedge clk) begin
		if (soft_reset) begin
			state <= mk14_pkg::ST_INIT;
			o_core_en <= 1'b0;
		end else begin
			case (state)
			mk14_pkg::ST_INIT: begin
				o_core_en <= 1'b0;
				timeout_cnt <= CNT_W'(RX_TIMEOUT_CYCLES - 1);
				state <= mk14_pkg::ST_RX_WAIT;
			end
			mk14_pkg::ST_RX_WAIT: begin
				// a parser error does not end the wait
				if (i_load_done || timeout_cnt == '0)
					state <= mk14_pkg::ST_START;
				else
					timeout_cnt <= timeout_cnt - 1'b1;
			end
			mk14_pkg::ST_START: begin
				o_core_en <= 1'b1;
				state <= mk14_pkg::ST_RUNNING;
			end
			mk14_pkg::ST_RUNNING: begin
				if (i_halt_key) begin
					o_core_en <= 1'b0;
					state <= mk14_pkg::ST_HALTED;
				end
			end
			mk14_pkg::ST_HALTED: begin
				if (!i_halt_key)
					state <= mk14_pkg::ST_START;	// resume without reload
			end
			default:
				state <= mk14_pkg::ST_INIT;
			endcase
		end
	end

endmodule

//--- src/intel_hex.sv
// intel hex record parser with memory write pulses, latched error code and end of file flag

module intel_hex (
	input logic clk,
	input logic soft_reset,
	input logic i_en,
	input logic [7:0] i_char,
	output mk14_pkg::mem_req_t o_req,
	output mk14_pkg::ihex_error_e o_error,
	output logic o_done
);

	localparam logic [7:0] CH_COLON = 8'h3a;
	localparam logic [7:0] CH_CR = 8'h0d;
	localparam logic [7:0] CH_LF = 8'h0a;

	typedef enum logic [2:0] {
		H_COLON,
		H_COUNT,
		H_ADDR_HI,
		H_ADDR_LO,
		H_TYPE,
		H_DATA,
		H_CSUM,
		H_HOLD	// after eof or error
	} hex_state_e;

	hex_state_e state;
	logic have_hi;
	logic [3:0] hi_nib;
	logic [4:0] digit;
	logic [7:0] cur_byte;
	logic [7:0] sum;
	logic [7:0] sum_next;
	logic [7:0] rec_count;
	logic [7:0] rec_type;
	logic [15:0] base_addr;
	logic [7:0] byte_idx;
	logic [7:0] idx_next;

	// {valid, value} of one ascii hex digit, either case
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] r;
		if (c >= "0" && c <= "9")
			r = {1'b1, 4'(c - "0")};
		else if (c >= "A" && c <= "F")
			r = {1'b1, 4'(c - "A" + 8'd10)};
		else if (c >= "a" && c <= "f")
			r = {1'b1, 4'(c - "a" + 8'd10)};
		else
			r = 5'd0;
		return r;
	endfunction

	assign digit = hex_digit(i_char);
	assign cur_byte = {hi_nib, digit[3:0]};
	assign sum_next = sum + cur_byte;
	assign idx_next = byte_idx + 8'd1;

	always_ff @(posedge clk) begin
		o_req.we <= 1'b0;	// one cycle write pulse
		if (soft_reset) begin
			state <= H_COLON;
			have_hi <= 1'b0;
			o_error <= mk14_pkg::ERR_NONE;
			o_done <= 1'b0;
		end else if (i_en) begin
			case (state)
			H_COLON: begin
				have_hi <= 1'b0;
				sum <= 8'd0;
				byte_idx <= 8'd0;
				if (i_char == CH_COLON)
					state <= H_COUNT;
				else if (i_char != CH_CR && i_char != CH_LF) begin	// line ends allowed
					o_error <= mk14_pkg::ERR_START;
					state <= H_HOLD;
				end
			end
			H_COUNT, H_ADDR_HI, H_ADDR_LO, H_TYPE, H_DATA, H_CSUM: begin
				if (!digit[4]) begin
					o_error <= mk14_pkg::ERR_DIGIT;
					state <= H_HOLD;
				end else if (!have_hi) begin
					hi_nib <= digit[3:0];
					have_hi <= 1'b1;
				end else begin
					have_hi <= 1'b0;
					sum <= sum_next;
					case (state)
					H_COUNT: begin
						rec_count <= cur_byte;
						state <= H_ADDR_HI;
					end
					H_ADDR_HI: begin
						base_addr[15:8] <= cur_byte;
						state <= H_ADDR_LO;
					end
					H_ADDR_LO: begin
						base_addr[7:0] <= cur_byte;
						state <= H_TYPE;
					end
					H_TYPE: begin
						rec_type <= cur_byte;
						if (cur_byte != mk14_pkg::REC_DATA && cur_byte != mk14_pkg::REC_EOF) begin
							o_error <= mk14_pkg::ERR_TYPE;
							state <= H_HOLD;
						end else
							state <= (rec_count == 8'd0) ? H_CSUM : H_DATA;
					end
					H_DATA: begin
						if (rec_type == mk14_pkg::REC_DATA) begin
							o_req.we <= 1'b1;
							o_req.addr <= base_addr + {8'h00, byte_idx};
							o_req.wdata <= cur_byte;
						end
						byte_idx <= idx_next;
						if (idx_next == rec_count)
							state <= H_CSUM;
					end
					default: begin	// checksum byte
						if (sum_next != 8'd0) begin
							o_error <= mk14_pkg::ERR_CHECKSUM;
							state <= H_HOLD;	// writes already done stay
						end else if (rec_type == mk14_pkg::REC_EOF) begin
							o_done <= 1'b1;
							state <= H_HOLD;
						end else
							state <= H_COLON;
					end
					endcase
				end
			end
			default: ;	// input ignored until reset
			endcase
		end
	end

endmodule

//--- src/mem_map.sv
// program ram with loader/core bus select, ff for reads outside ram

module mem_map #(
	parameter int RAM_ADDR_BITS = 10
)
(
	input logic clk,
	input logic i_loader_sel,
	input mk14_pkg::mem_req_t i_loader_req,
	input mk14_pkg::mem_req_t i_core_req,
	output logic [7:0] o_rdata
);

	localparam int RAM_BYTES = 2 ** RAM_ADDR_BITS;

	mk14_pkg::mem_req_t req;
	logic [RAM_ADDR_BITS-1:0] ram_addr;
	logic in_ram;
	logic in_ram_q;
	logic [7:0] ram_q;
	logic [7:0] ram [RAM_BYTES];

	assign req = i_loader_sel ? i_loader_req : i_core_req;	// loader owns bus in load window
	assign ram_addr = req.addr[RAM_ADDR_BITS-1:0];
	assign in_ram = (req.addr >> RAM_ADDR_BITS) == 16'd0;	// ram at address 0

	always_ff @(posedge clk) begin
		if (req.we && in_ram)
			ram[ram_addr] <= req.wdata;
		ram_q <= ram[ram_addr];
		in_ram_q <= in_ram;
	end

	// unmapped space reads as ff
	assign o_rdata = in_ram_q ? ram_q : 8'hff;

endmodule

//--- src/mk14_loader_soc.sv
// loader subsystem top with uart receiver, hex parser, memory map and boot sequencer

module mk14_loader_soc #(
	parameter int CLKS_PER_BIT = 434,
	parameter int RX_TIMEOUT_CYCLES = 100_000_000,
	parameter int RAM_ADDR_BITS = 10
)
(
	input logic clk,
	input logic soft_reset,
	input logic i_rx,
	input logic i_halt_key,
	input mk14_pkg::mem_req_t i_core_req,
	output logic [7:0] o_core_rdata,
	output logic o_rx_wait,
	output logic o_core_en,
	output mk14_pkg::ihex_error_e o_load_error
);

	logic [7:0] rx_byte;
	logic rx_valid;
	logic ihex_en;
	mk14_pkg::mem_req_t ihex_req;
	logic ihex_done;

	// parser only listens while load window open
	assign ihex_en = rx_valid && o_rx_wait;

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	)
	uart_rx_inst (
		.clk,
		.soft_reset,
		.i_rx,
		.o_byte(rx_byte),
		.o_valid(rx_valid)
	);

	intel_hex
	intel_hex_inst (
		.clk,
		.soft_reset,
		.i_en(ihex_en),
		.i_char(rx_byte),
		.o_req(ihex_req),
		.o_error(o_load_error),
		.o_done(ihex_done)
	);

	mem_map #(
		.RAM_ADDR_BITS(RAM_ADDR_BITS)
	)
	mem_map_inst (
		.clk,
		.i_loader_sel(o_rx_wait),
		.i_loader_req(ihex_req),
		.i_core_req,
		.o_rdata(o_core_rdata)
	);

	boot_sequencer #(
		.RX_TIMEOUT_CYCLES(RX_TIMEOUT_CYCLES)
	)
	boot_sequencer_inst (
		.clk,
		.soft_reset,
		.i_load_done(ihex_done),
		.i_halt_key,
		.o_rx_wait,
		.o_core_en
	);

endmodule

//--- src/mk14_pkg.sv
// memory request struct, hex parser error enum, boot state enum, hex record type codes

package mk14_pkg;

	// one bus access, 25 bits
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] wdata;
		logic we;
	} mem_req_t;

	// parser result, held until soft_reset
	typedef enum logic [2:0] {
		ERR_NONE = 3'd0,
		ERR_START = 3'd1,	// no colon at record start
		ERR_DIGIT = 3'd2,	// not a hex digit
		ERR_CHECKSUM = 3'd3,	// record sum not zero
		ERR_TYPE = 3'd4	// unsupported record type
	} ihex_error_e;

	typedef enum logic [2:0] {
		ST_INIT = 3'd0,
		ST_RX_WAIT = 3'd1,	// load window open
		ST_START = 3'd2,
		ST_RUNNING = 3'd3,
		ST_HALTED = 3'd4
	} boot_state_e;

	// intel hex record types
	localparam logic [7:0] REC_DATA = 8'h00;
	localparam logic [7:0] REC_EOF = 8'h01;

endpackage

//--- src/uart_rx.sv
// uart receiver, 8N1, one valid pulse per byte at mid stop bit

module uart_rx #(
	parameter int CLKS_PER_BIT = 434
)
(
	input logic clk,
	input logic soft_reset,
	input logic i_rx,
	output logic [7:0] o_byte,
	output logic o_valid
);

	localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e state;
	logic rx_meta;
	logic rx_sync;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;

	// two flops against metastability, idle high
	always_ff @(posedge clk) begin
		if (soft_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (soft_reset) begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
			RX_IDLE: begin
				clk_cnt <= '0;
				bit_idx <= '0;
				if (!rx_sync)
					state <= RX_START;	// falling start edge
			end
			RX_START: begin
				if (clk_cnt == HALF_LAST) begin
					clk_cnt <= '0;
					state <= rx_sync ? RX_IDLE : RX_DATA;	// glitch goes back to idle
				end else
					clk_cnt <= clk_cnt + 1'b1;
			end
			RX_DATA: begin
				if (clk_cnt == BIT_LAST) begin
					clk_cnt <= '0;
					shift <= {rx_sync, shift[7:1]};	// lsb first
					bit_idx <= bit_idx + 3'd1;
					if (bit_idx == 3'd7)
						state <= RX_STOP;
				end else
					clk_cnt <= clk_cnt + 1'b1;
			end
			default: begin
				if (clk_cnt == BIT_LAST)
					state <= RX_IDLE;
				else
					clk_cnt <= clk_cnt + 1'b1;
			end
			endcase
		end
	end

	assign o_byte = shift;
	assign o_valid = (state == RX_STOP) && (clk_cnt == BIT_LAST) && rx_sync;	// bad stop bit dropped

endmodule

//--- verif/tb_mk14_loader.sv
// testbench for the loader top with serial hex stimulus, core port reads and cycle limit

module tb_mk14_loader;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLKS_PER_BIT = 8;
	localparam int RX_TIMEOUT_CYCLES = 4000;
	localparam int RAM_ADDR_BITS = 10;
	localparam int RAM_BYTES = 2 ** RAM_ADDR_BITS;
	localparam int TOTAL_CHARS = 98;	// 45 + 26 + 13 + 14 over the tests
	localparam int CYCLE_LIMIT = TOTAL_CHARS * 10 * CLKS_PER_BIT + 2 * RX_TIMEOUT_CYCLES + 2000;

	logic clk;
	logic soft_reset;
	logic rx_line;
	logic halt_key;
	mk14_pkg::mem_req_t core_req;
	logic [7:0] core_rdata;
	logic rx_wait;
	logic core_en;
	mk14_pkg::ihex_error_e load_error;
	logic [7:0] exp_mem [RAM_BYTES];	// filled from the records sent
	logic [7:0] lfsr_state = 8'd37;
	int cycle_cnt = 0;

	mk14_loader_soc #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.RX_TIMEOUT_CYCLES(RX_TIMEOUT_CYCLES),
		.RAM_ADDR_BITS(RAM_ADDR_BITS)
	)
	DUT (
		.clk(clk),
		.soft_reset(soft_reset),
		.i_rx(rx_line),
		.i_halt_key(halt_key),
		.i_core_req(core_req),
		.o_core_rdata(core_rdata),
		.o_rx_wait(rx_wait),
		.o_core_en(core_en),
		.o_load_error(load_error)
	);

	always #10 clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at first failure");
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT)
			report_failure($sformatf("timeout: tests still running after %0d cycles",
				CYCLE_LIMIT));
	end

	always @(negedge clk) begin
		if (DUT.u_asserts.fail_count != 0)
			report_failure("a bound assertion on the DUT ports failed");
	end

	// galois form, taps x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return (s >> 1) ^ (s[0] ? 8'hb8 : 8'h00);
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr_state[0];	// one step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [7:0] hex_char(input logic [3:0] n);
		return (n < 4'd10) ? 8'h30 + 8'(n) : 8'h41 + 8'(n) - 8'd10;
	endfunction

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			report_failure($sformatf("Error %s: expected %02h, actual %02h", name, exp, act));
	endtask

	task automatic apply_reset();
		@(posedge clk);
		soft_reset <= 1'b1;
		rx_line <= 1'b1;
		halt_key <= 1'b0;
		core_req <= '0;
		repeat (10) @(posedge clk);
		soft_reset <= 1'b0;
	endtask

	// 8N1 frame, lsb first
	task automatic send_char(input logic [7:0] c);
		logic [9:0] frame;
		frame = {1'b1, c, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rx_line <= frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	task automatic send_hex(input logic [7:0] b);
		send_char(hex_char(b[7:4]));
		send_char(hex_char(b[3:0]));
	endtask

	task automatic send_record(input logic [7:0] rec_type, input logic [15:0] addr,
		input int count, input logic bad_csum);
		logic [7:0] sum;
		logic [7:0] b;
		logic [7:0] csum;
		sum = 8'(count) + addr[15:8] + addr[7:0] + rec_type;
		send_char(8'h3a);
		send_hex(8'(count));
		send_hex(addr[15:8]);
		send_hex(addr[7:0]);
		send_hex(rec_type);
		for (int i = 0; i < count; i++) begin
			random_byte(b);
			if (rec_type == mk14_pkg::REC_DATA && int'(addr) + i < RAM_BYTES)
				exp_mem[int'(addr) + i] = b;	// kept even if checksum is bad
			sum = sum + b;
			send_hex(b);
		end
		csum = 8'd0 - sum;
		if (bad_csum)
			csum = csum + 8'd1;
		send_hex(csum);
	endtask

	task automatic read_range(input string name, input logic [15:0] start, input int n);
		logic [15:0] a;
		logic [7:0] exp;
		for (int i = 0; i < n; i++) begin
			a = start + 16'(i);
			exp = (int'(a) < RAM_BYTES) ? exp_mem[a[RAM_ADDR_BITS-1:0]] : 8'hff;
			@(posedge clk);
			core_req <= '{addr: a, wdata: 8'h00, we: 1'b0};
			@(posedge clk);	// data one cycle after address
			@(negedge clk);
			check_value($sformatf("%s @%04h", name, a), exp, core_rdata);
		end
	endtask

	task automatic wait_core_en();
		@(negedge clk);
		while (!core_en)
			@(negedge clk);
	endtask

	task automatic wait_load_error(input string name, input mk14_pkg::ihex_error_e exp);
		int n;
		n = 0;
		while (load_error == mk14_pkg::ERR_NONE && n < 4 * CLKS_PER_BIT) begin
			@(negedge clk);
			n++;
		end
		check_value(name, exp, load_error);
	endtask

	initial begin
		int t0;
		clk = 1'b0;
		soft_reset = 1'b1;
		rx_line = 1'b1;
		halt_key = 1'b0;
		core_req = '0;

		// load and start
		apply_reset();
		t0 = cycle_cnt;
		send_record(mk14_pkg::REC_DATA, 16'h0000, 3, 1'b0);
		send_record(mk14_pkg::REC_DATA, 16'h03fd, 3, 1'b0);
		send_record(mk14_pkg::REC_EOF, 16'h0000, 0, 1'b0);
		wait_core_en();
		if (cycle_cnt - t0 >= RX_TIMEOUT_CYCLES)
			report_failure("core enable came from the load timeout, not from the EOF record");
		check_value("load error", mk14_pkg::ERR_NONE, load_error);
		read_range("load", 16'h0000, 3);
		read_range("load", 16'h03fd, 3);

		// halt and resume
		@(posedge clk);
		halt_key <= 1'b1;
		@(negedge clk);
		while (core_en)
			@(negedge clk);
		check_value("halt rx_wait", 8'd0, rx_wait);
		@(posedge clk);
		halt_key <= 1'b0;
		@(negedge clk);
		while (!core_en) begin
			check_value("resume rx_wait", 8'd0, rx_wait);	// no reload on resume
			@(negedge clk);
		end
		read_range("resume", 16'h0000, 3);
		read_range("resume", 16'h03fd, 3);

		// writes above the ram, contents kept over reset
		apply_reset();
		send_record(mk14_pkg::REC_DATA, 16'h0400, 2, 1'b0);
		send_record(mk14_pkg::REC_EOF, 16'h0000, 0, 1'b0);
		wait_core_en();
		read_range("out of range", 16'h0000, 3);
		read_range("out of range", 16'h03fd, 5);
		read_range("out of range", 16'hffff, 1);

		// bad checksum ends only by timeout
		apply_reset();
		t0 = cycle_cnt;
		send_record(mk14_pkg::REC_DATA, 16'h0100, 1, 1'b1);
		wait_load_error("checksum", mk14_pkg::ERR_CHECKSUM);
		wait_core_en();
		if (cycle_cnt - t0 < RX_TIMEOUT_CYCLES)
			report_failure("core enabled before the load timeout after a bad checksum");
		check_value("checksum held", mk14_pkg::ERR_CHECKSUM, load_error);
		read_range("checksum", 16'h0100, 1);

		// format errors
		apply_reset();
		send_char("X");
		wait_load_error("missing colon", mk14_pkg::ERR_START);
		apply_reset();
		send_char(8'h3a);
		send_char("G");
		wait_load_error("non-hex digit", mk14_pkg::ERR_DIGIT);
		apply_reset();
		send_record(8'h02, 16'h0000, 0, 1'b0);
		wait_load_error("record type", mk14_pkg::ERR_TYPE);

		@(negedge clk);
		if (DUT.u_asserts.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else
			report_failure("a bound assertion on the DUT ports failed");
	end

endmodule

//--- verif/tb_mk14_loader_asserts.sv
// bound assertions on loader top ports for core enable, load window, error code and halt key

module mk14_loader_asserts (
	input logic clk,
	input logic soft_reset,
	input logic i_core_en,
	input logic i_rx_wait,
	input logic i_halt_key,
	input mk14_pkg::ihex_error_e i_load_error,
	input mk14_pkg::boot_state_e i_boot_state
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;	// polled by testbench

	core_en_after_reset: assert property (@(posedge clk) soft_reset |=> !i_core_en)
		else begin
			fail_count = fail_count + 1;
			$error("core enable high in the cycle after reset");
		end

	core_en_not_in_load: assert property (@(posedge clk) disable iff (soft_reset)
		!(i_core_en && i_rx_wait))
		else begin
			fail_count = fail_count + 1;
			$error("core enable and load window high together");
		end

	load_error_held: assert property (@(posedge clk) disable iff (soft_reset)
		(i_load_error != mk14_pkg::ERR_NONE) |=> $stable(i_load_error))
		else begin
			fail_count = fail_count + 1;
			$error("load error code changed before reset");
		end

	// halt only acts from the running state
	halt_drops_core_en: assert property (@(posedge clk) disable iff (soft_reset)
		(i_boot_state == mk14_pkg::ST_RUNNING && i_halt_key) ##1 i_halt_key |-> !i_core_en)
		else begin
			fail_count = fail_count + 1;
			$error("core enable still high with halt key held two cycles");
		end

endmodule

bind mk14_loader_soc mk14_loader_asserts u_asserts (
	.clk(clk),
	.soft_reset(soft_reset),
	.i_core_en(o_core_en),
	.i_rx_wait(o_rx_wait),
	.i_halt_key(i_halt_key),
	.i_load_error(o_load_error),
	.i_boot_state(boot_sequencer_inst.state)
);
